//--- Makefile
# Verilator flow for the execute stage

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
RTL_TOP   ?= ex_stage
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -j 0
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

# Pass only when the testbench prints the pass line
sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- ex_alu.sv
//////////////////////////////////////////////////
// Integer ALU
// Single-cycle arithmetic, logic, shifts, set-less-than
// and branch comparison
//////////////////////////////////////////////////
`default_nettype none

module ex_alu import ex_stage_pkg::*; (
  input  logic [ALU_OP_W-1:0] operator_i,
  input  logic [XLEN-1:0]     operand_a_i,
  input  logic [XLEN-1:0]     operand_b_i,

  output logic [XLEN-1:0]     result_o,
  output logic                cmp_result_o
);

  // Shift amount from low bits of b
  logic [4:0]      shamt;

  // Shared comparator outputs
  logic            is_equal;
  logic            is_less_s;
  logic            is_less_u;

  // Per-class intermediate results
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] shift_res;

  assign shamt = operand_b_i[4:0];

  //////////////////////////////////////////////////
  // Comparators
  //////////////////////////////////////////////////

  assign is_equal  = (operand_a_i == operand_b_i);
  assign is_less_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_less_u = (operand_a_i < operand_b_i);

  // Branch condition for the six compare codes
  always_comb begin
    case (operator_i)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = ~is_equal;
      ALU_LT:  cmp_result_o = is_less_s;
      ALU_GE:  cmp_result_o = ~is_less_s;
      ALU_LTU: cmp_result_o = is_less_u;
      ALU_GEU: cmp_result_o = ~is_less_u;
      // No branch for other operators
      default: cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Adder and shifter
  //////////////////////////////////////////////////

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  always_comb begin
    case (operator_i)
      ALU_SLL: shift_res = operand_a_i << shamt;
      ALU_SRA: shift_res = $unsigned($signed(operand_a_i) >>> shamt);
      // Logical right shift
      default: shift_res = operand_a_i >> shamt;
    endcase
  end

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  result_o = shift_res;
      // Set-less-than gives 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, is_less_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, is_less_u};
      // Compare codes return the branch bit zero-extended
      default:  result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

//--- ex_mult.sv
//////////////////////////////////////////////////
// Integer multiplier
// MUL in one cycle, MULH/MULHSU/MULHU in two
//////////////////////////////////////////////////
`default_nettype none

module ex_mult import ex_stage_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                enable_i,
  input  logic [MUL_OP_W-1:0] operator_i,
  input  logic [XLEN-1:0]     op_a_i,
  input  logic [XLEN-1:0]     op_b_i,

  output logic [XLEN-1:0]     result_o,
  output logic                ready_o,
  output logic                multicycle_o,
  input  logic                ex_ready_i
);

  // High-word variants need the second cycle
  logic                   is_high;
  logic                   sign_a;
  logic                   sign_b;

  // Operands extended to 64 bits by signedness
  logic [2*XLEN-1:0]      op_a_ext;
  logic [2*XLEN-1:0]      op_b_ext;
  logic [2*XLEN-1:0]      prod_full;

  logic [XLEN-1:0]        prod_low;

  // Idle when low, done when high
  logic                   done_q;
  logic [2*XLEN-1:0]      prod_q;

  assign is_high = (operator_i != MUL_MUL);
  assign sign_a  = (operator_i == MUL_MULH) | (operator_i == MUL_MULHSU);
  assign sign_b  = (operator_i == MUL_MULH);

  assign op_a_ext  = {{XLEN{sign_a & op_a_i[XLEN-1]}}, op_a_i};
  assign op_b_ext  = {{XLEN{sign_b & op_b_i[XLEN-1]}}, op_b_i};
  assign prod_full = op_a_ext * op_b_ext;

  // Low word is the same for every signedness
  assign prod_low = op_a_i * op_b_i;

  //////////////////////////////////////////////////
  // Idle/done state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (!done_q) begin
      done_q <= enable_i & is_high;
    end else if (ex_ready_i) begin
      // Stage accepted the result
      done_q <= 1'b0;
    end
  end

  // Product captured while idle
  always_ff @(posedge clk) begin
    if (!done_q && enable_i && is_high) begin
      prod_q <= prod_full;
    end
  end

  // Stall only in the first cycle of a high variant
  assign ready_o      = ~(enable_i & is_high & ~done_q);
  assign multicycle_o = done_q;
  assign result_o     = done_q ? prod_q[2*XLEN-1:XLEN] : prod_low;

endmodule

`default_nettype wire

//--- ex_stage.f
ex_stage_pkg.sv
ex_alu.sv
ex_mult.sv
ex_tag_prop.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv

//--- ex_stage.sv
//////////////////////////////////////////////////
// Execute stage top level
// ALU, multiplier, tag propagation and write-back
//////////////////////////////////////////////////
`default_nettype none

module ex_stage import ex_stage_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  // ALU from ID
  input  logic [ALU_OP_W-1:0]  alu_operator_i,
  input  logic [XLEN-1:0]      alu_operand_a_i,
  input  logic [XLEN-1:0]      alu_operand_b_i,
  input  logic [XLEN-1:0]      alu_operand_c_i,
  input  logic                 alu_en_i,

  // Multiplier
  input  logic [MUL_OP_W-1:0]  mult_operator_i,
  input  logic [XLEN-1:0]      mult_operand_a_i,
  input  logic [XLEN-1:0]      mult_operand_b_i,
  input  logic                 mult_en_i,
  output logic                 mult_multicycle_o,

  // Tag propagation
  input  logic [OPCLASS_W-1:0] dift_opclass_i,
  input  logic [TPCR_W-1:0]    dift_tpcr_i,
  input  logic                 operand_a_tag_i,
  input  logic                 operand_b_tag_i,
  input  logic                 operand_c_tag_i,

  // CSR and load
  input  logic                 csr_access_i,
  input  logic [XLEN-1:0]      csr_rdata_i,
  input  logic                 lsu_en_i,
  input  logic [XLEN-1:0]      lsu_rdata_i,
  input  logic                 lsu_rtag_i,
  input  logic                 lsu_ready_ex_i,
  input  logic                 lsu_err_i,

  // Register file destinations
  input  logic                 regfile_alu_we_i,
  input  logic [RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                 regfile_we_i,
  input  logic [RF_ADDR_W-1:0] regfile_waddr_i,

  input  logic                 branch_in_ex_i,
  input  logic                 wb_ready_i,

  // Forward port to ID and register file
  output logic                 regfile_alu_we_fw_o,
  output logic [RF_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [XLEN-1:0]      regfile_alu_wdata_fw_o,
  output logic                 regfile_alu_wtag_fw_o,

  // Load write port
  output logic                 regfile_we_wb_o,
  output logic [RF_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [XLEN-1:0]      regfile_wdata_wb_o,
  output logic                 regfile_wtag_wb_o,

  output logic [XLEN-1:0]      jump_target_o,
  output logic                 branch_decision_o,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;
  logic            prop_tag;

  // Jump target computed in ID
  assign jump_target_o = alu_operand_c_i;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Done state released by the stage ready
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o),
    .ex_ready_i   (ex_ready_o)
  );

  ex_tag_prop u_tag_prop (
    .opclass_i (dift_opclass_i),
    .tpcr_i    (dift_tpcr_i),
    .tag_a_i   (operand_a_tag_i),
    .tag_b_i   (operand_b_tag_i),
    .tag_c_i   (operand_c_tag_i),
    .tag_o     (prop_tag)
  );

  //////////////////////////////////////////////////
  // Write-back and stall control
  //////////////////////////////////////////////////

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .tag_i                  (prop_tag),
    .lsu_rtag_i             (lsu_rtag_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_wtag_fw_o  (regfile_alu_wtag_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .regfile_wtag_wb_o      (regfile_wtag_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- ex_stage_pkg.sv
//////////////////////////////////////////////////
// Execute stage shared definitions
// Data widths, operator codes and tag encodings
//////////////////////////////////////////////////
`default_nettype none

package ex_stage_pkg;

  // Data path and register file widths
  localparam int XLEN      = 32;
  localparam int RF_ADDR_W = 6;

  //////////////////////////////////////////////////
  // ALU operators
  //////////////////////////////////////////////////
  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;
  // Branch comparisons
  localparam logic [ALU_OP_W-1:0] ALU_EQ   = 4'd10;
  localparam logic [ALU_OP_W-1:0] ALU_NE   = 4'd11;
  localparam logic [ALU_OP_W-1:0] ALU_LT   = 4'd12;
  localparam logic [ALU_OP_W-1:0] ALU_GE   = 4'd13;
  localparam logic [ALU_OP_W-1:0] ALU_LTU  = 4'd14;
  localparam logic [ALU_OP_W-1:0] ALU_GEU  = 4'd15;

  // Multiplier operators
  localparam int MUL_OP_W = 2;

  localparam logic [MUL_OP_W-1:0] MUL_MUL    = 2'd0;
  localparam logic [MUL_OP_W-1:0] MUL_MULH   = 2'd1;
  localparam logic [MUL_OP_W-1:0] MUL_MULHSU = 2'd2;
  localparam logic [MUL_OP_W-1:0] MUL_MULHU  = 2'd3;

  //////////////////////////////////////////////////
  // Tag propagation
  //////////////////////////////////////////////////
  localparam int OPCLASS_W = 2;

  localparam logic [OPCLASS_W-1:0] CLASS_ALU   = 2'd0;
  localparam logic [OPCLASS_W-1:0] CLASS_SHIFT = 2'd1;
  localparam logic [OPCLASS_W-1:0] CLASS_MUL   = 2'd2;
  localparam logic [OPCLASS_W-1:0] CLASS_CSR   = 2'd3;

  // Four 2-bit modes with class n at bits 2n+1..2n
  localparam int TPCR_W = 8;

  localparam logic [1:0] TAG_CLEAR = 2'd0;
  localparam logic [1:0] TAG_A     = 2'd1;
  localparam logic [1:0] TAG_AB    = 2'd2;
  localparam logic [1:0] TAG_ABC   = 2'd3;

endpackage

`default_nettype wire

//--- ex_tag_prop.sv
//////////////////////////////////////////////////
// Tag propagation
// Combines operand tags by the mode of the class
//////////////////////////////////////////////////
`default_nettype none

module ex_tag_prop import ex_stage_pkg::*; (
  input  logic [OPCLASS_W-1:0] opclass_i,
  input  logic [TPCR_W-1:0]    tpcr_i,
  input  logic                 tag_a_i,
  input  logic                 tag_b_i,
  input  logic                 tag_c_i,

  output logic                 tag_o
);

  // Mode field of the current class
  logic [1:0] mode;

  assign mode = tpcr_i[{opclass_i, 1'b0} +: 2];

  always_comb begin
    case (mode)
      TAG_CLEAR: tag_o = 1'b0;
      TAG_A:     tag_o = tag_a_i;
      TAG_AB:    tag_o = tag_a_i | tag_b_i;
      // Any tainted operand taints the result
      TAG_ABC:   tag_o = tag_a_i | tag_b_i | tag_c_i;
      default:   tag_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- ex_writeback.sv
//////////////////////////////////////////////////
// Execute stage write-back
// ALU port mux, EX/WB load-port register
// and stage ready/valid
//////////////////////////////////////////////////
`default_nettype none

module ex_writeback import ex_stage_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 alu_en_i,
  input  logic                 mult_en_i,
  input  logic                 csr_access_i,
  input  logic                 lsu_en_i,

  input  logic [XLEN-1:0]      alu_result_i,
  input  logic [XLEN-1:0]      mult_result_i,
  input  logic [XLEN-1:0]      csr_rdata_i,
  input  logic [XLEN-1:0]      lsu_rdata_i,
  input  logic                 tag_i,
  input  logic                 lsu_rtag_i,

  input  logic                 regfile_alu_we_i,
  input  logic [RF_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                 regfile_we_i,
  input  logic [RF_ADDR_W-1:0] regfile_waddr_i,

  input  logic                 mult_ready_i,
  input  logic                 lsu_ready_ex_i,
  input  logic                 lsu_err_i,
  input  logic                 wb_ready_i,
  input  logic                 branch_in_ex_i,

  output logic                 regfile_alu_we_fw_o,
  output logic [RF_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [XLEN-1:0]      regfile_alu_wdata_fw_o,
  output logic                 regfile_alu_wtag_fw_o,

  output logic                 regfile_we_wb_o,
  output logic [RF_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [XLEN-1:0]      regfile_wdata_wb_o,
  output logic                 regfile_wtag_wb_o,

  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  // Registered load-port write
  logic                 we_lsu_q;
  logic [RF_ADDR_W-1:0] waddr_lsu_q;

  //////////////////////////////////////////////////
  // ALU write port
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_wtag_fw_o  = tag_i;

  // CSR over multiplier over ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) regfile_alu_wdata_fw_o = alu_result_i;
    if (mult_en_i) regfile_alu_wdata_fw_o = mult_result_i;
    if (csr_access_i) regfile_alu_wdata_fw_o = csr_rdata_i;
  end

  //////////////////////////////////////////////////
  // EX/WB load-port register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      // Faulting loads never write
      we_lsu_q <= regfile_we_i & ~lsu_err_i;
    end else if (wb_ready_i) begin
      // Nothing new so the slot empties
      we_lsu_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i && !lsu_err_i) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  // Load data arrives in WB and passes straight through
  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;
  assign regfile_wtag_wb_o  = lsu_rtag_i;

  // Branches finish in EX so they ignore WB back-pressure
  assign ex_ready_o = (mult_ready_i & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready_i & lsu_ready_ex_i & wb_ready_i;

endmodule

`default_nettype wire

//--- tb_ex_stage.sv
//////////////////////////////////////////////////
// Execute stage testbench
// LFSR stimulus checked against reference models
//////////////////////////////////////////////////
`default_nettype none

module tb_ex_stage import ex_stage_pkg::*; ();

  // Test lengths in instructions
  localparam int N_ALU = 200;
  localparam int N_BR  = 80;
  localparam int N_MUL = 80;
  localparam int N_TAG = 100;
  localparam int N_LD  = 100;
  localparam int N_CSR = 50;
  // High multiplies take up to three cycles with back-pressure
  localparam int PLAN_CYCLES = 5 + N_ALU + N_BR + 3 * N_MUL + N_TAG + N_LD + N_CSR + 5;
  localparam int MAX_CYCLES  = PLAN_CYCLES * 3 / 2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [ALU_OP_W-1:0]  alu_operator_i;
  logic [XLEN-1:0]      alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic [MUL_OP_W-1:0]  mult_operator_i;
  logic [XLEN-1:0]      mult_operand_a_i, mult_operand_b_i;
  logic [OPCLASS_W-1:0] dift_opclass_i;
  logic [TPCR_W-1:0]    dift_tpcr_i;
  logic [XLEN-1:0]      csr_rdata_i, lsu_rdata_i;
  logic [RF_ADDR_W-1:0] regfile_alu_waddr_i, regfile_waddr_i;
  logic                 alu_en_i, mult_en_i, csr_access_i, lsu_en_i;
  logic                 operand_a_tag_i, operand_b_tag_i, operand_c_tag_i, lsu_rtag_i;
  logic                 lsu_ready_ex_i, lsu_err_i, regfile_alu_we_i, regfile_we_i;
  logic                 branch_in_ex_i, wb_ready_i;

  // DUT outputs
  logic                 mult_multicycle_o, regfile_alu_we_fw_o, regfile_alu_wtag_fw_o;
  logic                 regfile_we_wb_o, regfile_wtag_wb_o, branch_decision_o;
  logic                 ex_ready_o, ex_valid_o;
  logic [RF_ADDR_W-1:0] regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  logic [XLEN-1:0]      regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;

  logic [31:0]          lfsr_q = 32'd95335;
  int                   cycle_count = 0;

  ex_stage UUT (.*);

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Random source and failure handling
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic logic [31:0] random_word(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic fail_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
    assert (got === want)
      else fail_run($sformatf("%s is %h, expected %h", what, got, want));
  endtask

  task automatic expect_bit(input string what, input logic got, input logic want);
    assert (got === want)
      else fail_run($sformatf("%s is %b, expected %b", what, got, want));
  endtask

  // Branches resolve in EX whatever WB does
  assert property (@(posedge clk) disable iff (!rst_n) branch_in_ex_i |-> ex_ready_o)
    else fail_run("branch in EX without ex_ready_o");

  // WB back-pressure stalls everything but a branch
  assert property (@(posedge clk) disable iff (!rst_n)
                   !wb_ready_i |-> !ex_valid_o && (ex_ready_o == branch_in_ex_i))
    else fail_run("ex_ready_o or ex_valid_o ignores wb_ready_i low");

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////

  // Differing signs decide and equal signs compare unsigned
  function automatic logic less_signed(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    if (a[XLEN-1] != b[XLEN-1]) begin
      return a[XLEN-1];
    end
    return a < b;
  endfunction

  function automatic logic cmp_model(input logic [ALU_OP_W-1:0] op,
                                     input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return less_signed(a, b);
      ALU_GE:  return !less_signed(a, b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input logic [ALU_OP_W-1:0] op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      // Vacated top bits take the sign
      ALU_SRA:  return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
      ALU_SLT:  return XLEN'(less_signed(a, b));
      ALU_SLTU: return XLEN'(a < b);
      default:  return XLEN'(cmp_model(op, a, b));
    endcase
  endfunction

  // Full 64-bit product of the extended operands
  function automatic logic [XLEN-1:0] mult_model(input logic [MUL_OP_W-1:0] op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ax;
    logic [2*XLEN-1:0] bx;
    logic [2*XLEN-1:0] p;
    ax = {{XLEN{1'b0}}, a};
    bx = {{XLEN{1'b0}}, b};
    if (op == MUL_MULH || op == MUL_MULHSU) begin
      ax = {{XLEN{a[XLEN-1]}}, a};
    end
    if (op == MUL_MULH) begin
      bx = {{XLEN{b[XLEN-1]}}, b};
    end
    p = ax * bx;
    if (op == MUL_MUL) begin
      return p[XLEN-1:0];
    end
    return p[2*XLEN-1:XLEN];
  endfunction

  function automatic logic tag_model(input logic [OPCLASS_W-1:0] cls,
                                     input logic [TPCR_W-1:0] tpcr,
                                     input logic ta, input logic tb, input logic tc);
    logic [1:0] mode;
    case (cls)
      CLASS_ALU:   mode = tpcr[1:0];
      CLASS_SHIFT: mode = tpcr[3:2];
      CLASS_MUL:   mode = tpcr[5:4];
      default:     mode = tpcr[7:6];
    endcase
    case (mode)
      TAG_A:   return ta;
      TAG_AB:  return ta | tb;
      TAG_ABC: return ta | tb | tc;
      default: return 1'b0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // Idle stage with WB and LSU ready
  task automatic clear_inputs();
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = MUL_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    dift_opclass_i      = CLASS_ALU;
    dift_tpcr_i         = '0;
    operand_a_tag_i     = 1'b0;
    operand_b_tag_i     = 1'b0;
    operand_c_tag_i     = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_rtag_i          = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    branch_in_ex_i      = 1'b0;
    wb_ready_i          = 1'b1;
  endtask

  // Random operand pair that is equal one time in four
  task automatic pick_alu_operands();
    alu_operand_a_i = random_word(XLEN);
    alu_operand_b_i = random_word(XLEN);
    if (random_word(2) == 0) begin
      alu_operand_b_i = alu_operand_a_i;
    end
  endtask

  task automatic exercise_alu();
    for (int i = 0; i < N_ALU; i++) begin
      next_cycle();
      clear_inputs();
      alu_en_i            = 1'b1;
      alu_operator_i      = ALU_OP_W'(random_word(ALU_OP_W));
      pick_alu_operands();
      regfile_alu_we_i    = lfsr_step();
      regfile_alu_waddr_i = RF_ADDR_W'(random_word(RF_ADDR_W));
      #5;
      compare_word("ALU forward data", regfile_alu_wdata_fw_o,
                   alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i));
      expect_bit("forward write enable", regfile_alu_we_fw_o, regfile_alu_we_i);
      compare_word("forward address", XLEN'(regfile_alu_waddr_fw_o),
                   XLEN'(regfile_alu_waddr_i));
      expect_bit("ex_valid_o for ALU", ex_valid_o, 1'b1);
    end
  endtask

  task automatic resolve_branches();
    for (int i = 0; i < N_BR; i++) begin
      next_cycle();
      clear_inputs();
      alu_en_i        = 1'b1;
      branch_in_ex_i  = 1'b1;
      // Cycle through the six compare codes
      alu_operator_i  = ALU_EQ + ALU_OP_W'(i % 6);
      pick_alu_operands();
      alu_operand_c_i = random_word(XLEN);
      wb_ready_i      = lfsr_step();
      #5;
      expect_bit("branch decision", branch_decision_o,
                 cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i));
      compare_word("jump target", jump_target_o, alu_operand_c_i);
      expect_bit("ex_ready_o with branch", ex_ready_o, 1'b1);
      expect_bit("ex_valid_o with branch", ex_valid_o, wb_ready_i);
    end
  endtask

  task automatic multiply_ops();
    logic [XLEN-1:0] want;
    for (int i = 0; i < N_MUL; i++) begin
      next_cycle();
      clear_inputs();
      mult_en_i        = 1'b1;
      regfile_alu_we_i = 1'b1;
      mult_operator_i  = MUL_OP_W'(random_word(MUL_OP_W));
      mult_operand_a_i = random_word(XLEN);
      mult_operand_b_i = random_word(XLEN);
      want = mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
      #5;
      if (mult_operator_i == MUL_MUL) begin
        compare_word("MUL low word", regfile_alu_wdata_fw_o, want);
        expect_bit("ex_ready_o for MUL", ex_ready_o, 1'b1);
        expect_bit("multicycle for MUL", mult_multicycle_o, 1'b0);
      end else begin
        // First cycle stalls while the product is registered
        expect_bit("ex_ready_o in first cycle", ex_ready_o, 1'b0);
        expect_bit("ex_valid_o in first cycle", ex_valid_o, 1'b0);
        expect_bit("multicycle in first cycle", mult_multicycle_o, 1'b0);
        next_cycle();
        if (random_word(2) == 0) begin
          // WB stall keeps the done state
          wb_ready_i = 1'b0;
          #5;
          expect_bit("ex_ready_o under back-pressure", ex_ready_o, 1'b0);
          next_cycle();
          wb_ready_i = 1'b1;
        end
        #5;
        compare_word("high word", regfile_alu_wdata_fw_o, want);
        expect_bit("multicycle in second cycle", mult_multicycle_o, 1'b1);
        expect_bit("ex_ready_o in second cycle", ex_ready_o, 1'b1);
      end
    end
  endtask

  task automatic propagate_tags();
    for (int i = 0; i < N_TAG; i++) begin
      next_cycle();
      clear_inputs();
      alu_en_i         = 1'b1;
      regfile_alu_we_i = 1'b1;
      dift_opclass_i   = OPCLASS_W'(random_word(OPCLASS_W));
      dift_tpcr_i      = TPCR_W'(random_word(TPCR_W));
      operand_a_tag_i  = lfsr_step();
      operand_b_tag_i  = lfsr_step();
      operand_c_tag_i  = lfsr_step();
      #5;
      expect_bit("forwarded tag", regfile_alu_wtag_fw_o,
                 tag_model(dift_opclass_i, dift_tpcr_i,
                           operand_a_tag_i, operand_b_tag_i, operand_c_tag_i));
    end
  endtask

  task automatic load_writes();
    logic                 want_we;
    logic [RF_ADDR_W-1:0] want_addr;
    logic                 valid;
    // Previous cycle wrote no load
    want_we   = 1'b0;
    want_addr = '0;
    for (int i = 0; i < N_LD; i++) begin
      next_cycle();
      clear_inputs();
      lsu_en_i        = 1'b1;
      regfile_we_i    = lfsr_step();
      regfile_waddr_i = RF_ADDR_W'(random_word(RF_ADDR_W));
      lsu_err_i       = (random_word(2) == 0);
      wb_ready_i      = (random_word(2) != 0);
      lsu_ready_ex_i  = (random_word(3) != 0);
      lsu_rdata_i     = random_word(XLEN);
      lsu_rtag_i      = lfsr_step();
      #5;
      // Registered write from the last edge
      expect_bit("load write enable", regfile_we_wb_o, want_we);
      if (want_we) begin
        compare_word("load write address", XLEN'(regfile_waddr_wb_o), XLEN'(want_addr));
      end
      compare_word("load write data", regfile_wdata_wb_o, lsu_rdata_i);
      expect_bit("load write tag", regfile_wtag_wb_o, lsu_rtag_i);
      valid = wb_ready_i & lsu_ready_ex_i;
      expect_bit("ex_valid_o for load", ex_valid_o, valid);
      if (valid) begin
        want_we = regfile_we_i & ~lsu_err_i;
        if (want_we) begin
          want_addr = regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        want_we = 1'b0;
      end
    end
  endtask

  task automatic forward_priority();
    logic [XLEN-1:0] want;
    for (int i = 0; i < N_CSR; i++) begin
      next_cycle();
      clear_inputs();
      alu_en_i         = lfsr_step();
      mult_en_i        = lfsr_step();
      csr_access_i     = lfsr_step();
      alu_operator_i   = ALU_OP_W'(random_word(ALU_OP_W));
      pick_alu_operands();
      mult_operand_a_i = random_word(XLEN);
      mult_operand_b_i = random_word(XLEN);
      csr_rdata_i      = random_word(XLEN);
      // CSR over multiplier over ALU
      if (csr_access_i) begin
        want = csr_rdata_i;
      end else if (mult_en_i) begin
        want = mult_model(MUL_MUL, mult_operand_a_i, mult_operand_b_i);
      end else begin
        want = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      end
      #5;
      if (alu_en_i | mult_en_i | csr_access_i) begin
        compare_word("forward data priority", regfile_alu_wdata_fw_o, want);
      end
    end
  endtask

  // Load write and stalled MULHU pending before reset
  task automatic reset_mid_run();
    next_cycle();
    clear_inputs();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = RF_ADDR_W'(random_word(RF_ADDR_W));
    next_cycle();
    clear_inputs();
    mult_en_i       = 1'b1;
    mult_operator_i = MUL_MULHU;
    wb_ready_i      = 1'b0;
    next_cycle();
    #5;
    expect_bit("load write before reset", regfile_we_wb_o, 1'b1);
    expect_bit("multicycle before reset", mult_multicycle_o, 1'b1);
    rst_n = 1'b0;
    #5;
    expect_bit("regfile_we_wb_o in reset", regfile_we_wb_o, 1'b0);
    expect_bit("mult_multicycle_o in reset", mult_multicycle_o, 1'b0);
    next_cycle();
    rst_n = 1'b1;
    clear_inputs();
    #5;
    expect_bit("regfile_we_wb_o after reset", regfile_we_wb_o, 1'b0);
    expect_bit("mult_multicycle_o after reset", mult_multicycle_o, 1'b0);
  endtask

  initial begin
    rst_n = 1'b0;
    clear_inputs();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #5;
    expect_bit("regfile_we_wb_o after reset", regfile_we_wb_o, 1'b0);
    expect_bit("mult_multicycle_o after reset", mult_multicycle_o, 1'b0);
    exercise_alu();
    resolve_branches();
    multiply_ops();
    propagate_tags();
    load_writes();
    forward_priority();
    reset_mid_run();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
